// ==== Bender.yml ====
package:
  name: dcache_sys

sources:
  - verilog/cache_geom_pkg.sv
  - verilog/cache_op_pkg.sv
  - verilog/way_ram.sv
  - verilog/apb_front.sv
  - verilog/dcache.sv
  - verilog/backing_mem.sv
  - verilog/dcache_sys.sv
  - target: simulation
    files:
      - testbench/tb_dcache_sys.sv

// ==== dcache_sys.f ====
verilog/cache_geom_pkg.sv
verilog/cache_op_pkg.sv
verilog/way_ram.sv
verilog/apb_front.sv
verilog/dcache.sv
verilog/backing_mem.sv
verilog/dcache_sys.sv
testbench/tb_dcache_sys.sv

// ==== testbench/tb_dcache_sys.sv ====
`timescale 1ns/10ps

module tb_dcache_sys;

    // 2 + 6 + 1 + 300 + 4 transfers over the five tests.
    localparam int num_xfers = 313;
    localparam int timeout_cycles = 40 * num_xfers;

    logic                                 g;
    logic                                 rst_n;
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    logic [cache_geom_pkg::addr_w-1:0]    paddr;
    logic [cache_geom_pkg::word_w-1:0]    pwdata;
    logic [cache_geom_pkg::word_w-1:0]    prdata;
    logic                                 pready;
    logic                                 pslverr;

    logic [cache_geom_pkg::word_w-1:0] model [cache_geom_pkg::mem_words];  // Flat memory.
    int cycles = 0;
    int checks;
    int errors;
    int tests_failed;

    dcache_sys UUT (
        .g       (g),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 g = ~g;

    always @(posedge g) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB driver and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [cache_geom_pkg::addr_w-1:0] byte_addr(
        input logic [cache_geom_pkg::tag_w-1:0]   tag,
        input logic [cache_geom_pkg::index_w-1:0] index
    );
        byte_addr = '0;
        byte_addr[cache_geom_pkg::word_addr_top-1:cache_geom_pkg::byte_off_w] = {tag, index};
    endfunction

    task automatic apb_access(
        input  cache_op_pkg::op_e                 op,
        input  logic [cache_geom_pkg::addr_w-1:0] addr,
        input  logic [cache_geom_pkg::word_w-1:0] wdata,
        output logic [cache_geom_pkg::word_w-1:0] rdata,
        output logic                              err
    );
        @(negedge g);
        psel = 1'b1;                                 // Setup phase.
        penable = 1'b0;
        pwrite = (op == cache_op_pkg::OP_WRITE);
        paddr = addr;
        pwdata = wdata;
        @(negedge g);
        penable = 1'b1;
        // The transfer completes on the rising edge where pready is high.
        @(posedge g);
        while (!pready) begin
            @(posedge g);
        end
        rdata = prdata;
        err = pslverr;
        @(negedge g);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(
        input string                             name,
        input logic [cache_geom_pkg::word_w-1:0] exp,
        input logic [cache_geom_pkg::word_w-1:0] act
    );
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s read data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s pslverr expected %b actual %b", name, exp, act);
        end
    endtask

    // One access through the DUT, mirrored in the model.
    task automatic run_op(
        input string                              name,
        input cache_op_pkg::op_e                  op,
        input logic [cache_geom_pkg::tag_w-1:0]   tag,
        input logic [cache_geom_pkg::index_w-1:0] index,
        input logic [cache_geom_pkg::word_w-1:0]  data
    );
        logic [cache_geom_pkg::word_w-1:0] rdata;
        logic err;
        apb_access(op, byte_addr(tag, index), data, rdata, err);
        check_err(name, 1'b0, err);
        case (op)
            cache_op_pkg::OP_WRITE: model[{tag, index}] = data;
            default: check_word(name, model[{tag, index}], rdata);
        endcase
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s passed", name);
        end else begin
            tests_failed++;
            $display("%s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int errors_before;
        logic [cache_geom_pkg::word_w-1:0] rdata;
        logic err;
        cache_op_pkg::op_e op;
        logic [cache_geom_pkg::tag_w-1:0] tag;
        logic [cache_geom_pkg::index_w-1:0] index;

        g = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        checks = 0;
        errors = 0;
        tests_failed = 0;
        void'($urandom(19));
        for (int i = 0; i < cache_geom_pkg::mem_words; i++) begin
            model[i] = '0;
        end
        repeat (10) @(negedge g);
        rst_n = 1'b1;

        errors_before = errors;
        run_op("write_read", cache_op_pkg::OP_WRITE, 6'h2a, 4'h3, 32'hdead_beef);
        run_op("write_read", cache_op_pkg::OP_READ, 6'h2a, 4'h3, '0);
        end_test("write_read", errors_before);

        // Three tags in one two-way set force a dirty eviction.
        errors_before = errors;
        for (int t = 1; t <= 3; t++) begin
            run_op("eviction", cache_op_pkg::OP_WRITE, 6'(t), 4'h9, 32'h1111_0000 + t);
        end
        for (int t = 1; t <= 3; t++) begin
            run_op("eviction", cache_op_pkg::OP_READ, 6'(t), 4'h9, '0);
        end
        end_test("eviction", errors_before);

        errors_before = errors;
        run_op("unwritten", cache_op_pkg::OP_READ, 6'h3f, 4'hf, '0);
        end_test("unwritten", errors_before);

        errors_before = errors;
        for (int n = 0; n < 300; n++) begin
            op = ($urandom & 1) ? cache_op_pkg::OP_WRITE : cache_op_pkg::OP_READ;
            tag = 6'($urandom % 4);
            index = 4'($urandom % 4);
            run_op("random", op, tag, index, $urandom);
        end
        end_test("random", errors_before);

        errors_before = errors;
        run_op("addr_error", cache_op_pkg::OP_WRITE, 6'h05, 4'h2, 32'h600d_0005);
        apb_access(cache_op_pkg::OP_WRITE, byte_addr(6'h05, 4'h2) | 32'h2, 32'hbad0_0001,
                   rdata, err);
        check_err("addr_error", 1'b1, err);
        apb_access(cache_op_pkg::OP_WRITE, byte_addr(6'h05, 4'h2) | 32'h0001_0000,
                   32'hbad0_0002, rdata, err);
        check_err("addr_error", 1'b1, err);
        run_op("addr_error", cache_op_pkg::OP_READ, 6'h05, 4'h2, '0);
        end_test("addr_error", errors_before);

        $display("Tests run 5, tests failed %0d, checks %0d, errors %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/apb_front.sv ====
`timescale 1ns/10ps

module apb_front (
    input  logic                                 g,
    input  logic                                 rst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [cache_geom_pkg::addr_w-1:0]    paddr,
    input  logic [cache_geom_pkg::word_w-1:0]    pwdata,
    output logic [cache_geom_pkg::word_w-1:0]    prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 req,
    output cache_op_pkg::op_e                    req_op,
    output logic [cache_geom_pkg::index_w-1:0]   req_index,
    output logic [cache_geom_pkg::tag_w-1:0]     req_tag,
    output logic [cache_geom_pkg::word_w-1:0]    req_wdata,
    input  logic                                 rsp,
    input  logic [cache_geom_pkg::word_w-1:0]    rsp_rdata
);

    cache_op_pkg::apb_state_e state, state_nxt;
    logic access;
    logic addr_bad;
    logic [cache_op_pkg::status_w-1:0] addr_status;

    assign access = psel & penable;

    assign addr_status[cache_op_pkg::stat_misalign] =
        |paddr[cache_geom_pkg::byte_off_w-1:0];
    assign addr_status[cache_op_pkg::stat_range] =
        |paddr[cache_geom_pkg::addr_w-1:cache_geom_pkg::word_addr_top];
    assign addr_bad = |addr_status;

    // APB keeps paddr and pwdata steady through the access phase,
    // so the request fields need no holding register here.
    assign {req_tag, req_index} =
        paddr[cache_geom_pkg::word_addr_top-1:cache_geom_pkg::byte_off_w];
    assign req_op = pwrite ? cache_op_pkg::OP_WRITE : cache_op_pkg::OP_READ;
    assign req_wdata = pwdata;

    assign req = (state == cache_op_pkg::AP_IDLE) & access & ~addr_bad;

    always_comb begin
        pready = 1'b0;
        pslverr = 1'b0;
        prdata = '0;
        if (state == cache_op_pkg::AP_IDLE) begin
            pready = access & addr_bad;      // Faulty address ends in its first access cycle.
            pslverr = access & addr_bad;
        end else begin
            pready = rsp;
            prdata = rsp ? rsp_rdata : '0;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            cache_op_pkg::AP_IDLE: if (req) state_nxt = cache_op_pkg::AP_WAIT;
            cache_op_pkg::AP_WAIT: if (rsp) state_nxt = cache_op_pkg::AP_IDLE;
            default: state_nxt = cache_op_pkg::AP_IDLE;
        endcase
    end

    always_ff @(posedge g or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_op_pkg::AP_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // The cache only answers a request that this block issued.
    a_rsp_in_wait: assert property (@(posedge g) disable iff (!rst_n)
        rsp |-> state == cache_op_pkg::AP_WAIT);

endmodule

// ==== verilog/backing_mem.sv ====
`timescale 1ns/10ps

module backing_mem (
    input  logic                                         g,
    input  logic                                         rst_n,
    input  logic                                         mem_req,
    input  logic                                         mem_we,
    input  logic [cache_geom_pkg::mem_words_log2-1:0]    mem_addr,
    input  logic [cache_geom_pkg::word_w-1:0]            mem_wdata,
    output logic                                         mem_ack,
    output logic [cache_geom_pkg::word_w-1:0]            mem_rdata
);

    logic [cache_geom_pkg::word_w-1:0] mem [cache_geom_pkg::mem_words] = '{default: '0};
    logic start;

    // A request held through its ack cycle is not run a second time.
    assign start = mem_req & ~mem_ack;

    always_ff @(posedge g or negedge rst_n) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= start;
        end
    end

    always_ff @(posedge g) begin
        if (start) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end
            mem_rdata <= mem[mem_addr];            // Valid alongside mem_ack.
        end
    end

    a_addr_stable: assert property (@(posedge g) disable iff (!rst_n)
        mem_req && !mem_ack |=> $stable(mem_addr));

endmodule

// ==== verilog/cache_geom_pkg.sv ====
package cache_geom_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Processor side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int addr_w = 32;              // APB byte address.
    localparam int word_w = 32;
    localparam int byte_off_w = 2;           // Byte offset below the word address.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Backing memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int mem_words_log2 = 10;      // 1024 words.
    localparam int mem_words = 1 << mem_words_log2;

    // Every paddr bit from here up must be zero for an in-range access.
    localparam int word_addr_top = byte_off_w + mem_words_log2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A line is a single word, so the word address splits
    // straight into tag and index with no line offset.
    localparam int index_w = 4;
    localparam int tag_w = mem_words_log2 - index_w;
    localparam int num_sets = 1 << index_w;

    localparam int num_ways = 2;             // The controller is built for two ways.

endpackage

// ==== verilog/cache_op_pkg.sv ====
package cache_op_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // Cache controller.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_DONE
    } ctrl_state_e;

    // APB front end.
    typedef enum logic {
        AP_IDLE,
        AP_WAIT
    } apb_state_e;

    // Address check status, one flag per fault kind.
    localparam int status_w = 2;
    localparam int stat_misalign = 0;
    localparam int stat_range = 1;

endpackage

// ==== verilog/dcache.sv ====
`timescale 1ns/10ps

module dcache (
    input  logic                                         g,
    input  logic                                         rst_n,
    input  logic                                         req,
    input  cache_op_pkg::op_e                            req_op,
    input  logic [cache_geom_pkg::index_w-1:0]           req_index,
    input  logic [cache_geom_pkg::tag_w-1:0]             req_tag,
    input  logic [cache_geom_pkg::word_w-1:0]            req_wdata,
    output logic                                         rsp,
    output logic [cache_geom_pkg::word_w-1:0]            rsp_rdata,
    output logic                                         mem_req,
    output logic                                         mem_we,
    output logic [cache_geom_pkg::mem_words_log2-1:0]    mem_addr,
    output logic [cache_geom_pkg::word_w-1:0]            mem_wdata,
    input  logic                                         mem_ack,
    input  logic [cache_geom_pkg::word_w-1:0]            mem_rdata
);

    cache_op_pkg::ctrl_state_e state, state_nxt;
    logic [cache_geom_pkg::num_sets-1:0] lru;       // Points at the next victim way.
    logic victim_q;
    logic lookup_victim;
    logic [cache_geom_pkg::num_ways-1:0] hit;
    logic [cache_geom_pkg::num_ways-1:0] way_we;
    logic wr_dirty;
    logic [cache_geom_pkg::word_w-1:0] wr_data;
    logic [cache_geom_pkg::num_ways-1:0] rd_valid;
    logic [cache_geom_pkg::num_ways-1:0] rd_dirty;
    logic [cache_geom_pkg::tag_w-1:0] rd_tag [cache_geom_pkg::num_ways];
    logic [cache_geom_pkg::word_w-1:0] rd_data [cache_geom_pkg::num_ways];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign hit[0] = rd_valid[0] & (rd_tag[0] == req_tag);
    assign hit[1] = rd_valid[1] & (rd_tag[1] == req_tag);
    assign lookup_victim = lru[req_index];

    always_comb begin
        state_nxt = state;
        case (state)
            cache_op_pkg::ST_IDLE: if (req) state_nxt = cache_op_pkg::ST_LOOKUP;
            cache_op_pkg::ST_LOOKUP: begin
                if (|hit) begin
                    state_nxt = cache_op_pkg::ST_DONE;
                end else if (rd_valid[lookup_victim] & rd_dirty[lookup_victim]) begin
                    state_nxt = cache_op_pkg::ST_WRITEBACK;
                end else begin
                    state_nxt = cache_op_pkg::ST_REFILL;
                end
            end
            cache_op_pkg::ST_WRITEBACK: if (mem_ack) state_nxt = cache_op_pkg::ST_REFILL;
            cache_op_pkg::ST_REFILL: begin
                if (req_op == cache_op_pkg::OP_WRITE || mem_ack) begin
                    state_nxt = cache_op_pkg::ST_DONE;
                end
            end
            default: state_nxt = cache_op_pkg::ST_IDLE;  // ST_DONE lasts one cycle.
        endcase
    end

    always_ff @(posedge g or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_op_pkg::ST_IDLE;
            lru <= '0;
            victim_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == cache_op_pkg::ST_LOOKUP) begin
                victim_q <= lookup_victim;
            end
            if (state == cache_op_pkg::ST_LOOKUP && |hit) begin
                lru[req_index] <= hit[0];
            end else if (state == cache_op_pkg::ST_REFILL && |way_we) begin
                lru[req_index] <= ~victim_q;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Way updates and memory port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A write miss fills the line from the write data, so only read
    // misses fetch from memory.
    always_comb begin
        way_we = '0;
        wr_dirty = 1'b1;
        wr_data = req_wdata;
        if (state == cache_op_pkg::ST_LOOKUP && req_op == cache_op_pkg::OP_WRITE) begin
            way_we = hit;
        end else if (state == cache_op_pkg::ST_REFILL) begin
            if (req_op == cache_op_pkg::OP_WRITE) begin
                way_we[victim_q] = 1'b1;
            end else if (mem_ack) begin
                way_we[victim_q] = 1'b1;
                wr_dirty = 1'b0;
                wr_data = mem_rdata;
            end
        end
    end

    assign mem_we = (state == cache_op_pkg::ST_WRITEBACK);
    assign mem_req = mem_we |
        (state == cache_op_pkg::ST_REFILL && req_op == cache_op_pkg::OP_READ);
    // The arrays still show the victim during write-back.
    assign mem_addr = mem_we ? {rd_tag[victim_q], req_index} : {req_tag, req_index};
    assign mem_wdata = rd_data[victim_q];

    always_ff @(posedge g) begin
        if (state == cache_op_pkg::ST_LOOKUP) begin
            rsp_rdata <= hit[1] ? rd_data[1] : rd_data[0];
        end else if (state == cache_op_pkg::ST_REFILL && mem_ack) begin
            rsp_rdata <= mem_rdata;
        end
    end

    assign rsp = (state == cache_op_pkg::ST_DONE);

    way_ram way0 (
        .g        (g),
        .rst_n    (rst_n),
        .rd_index (req_index),
        .wr_en    (way_we[0]),
        .wr_index (req_index),
        .wr_valid (1'b1),
        .wr_dirty (wr_dirty),
        .wr_tag   (req_tag),
        .wr_data  (wr_data),
        .rd_valid (rd_valid[0]),
        .rd_dirty (rd_dirty[0]),
        .rd_tag   (rd_tag[0]),
        .rd_data  (rd_data[0])
    );

    way_ram way1 (
        .g        (g),
        .rst_n    (rst_n),
        .rd_index (req_index),
        .wr_en    (way_we[1]),
        .wr_index (req_index),
        .wr_valid (1'b1),
        .wr_dirty (wr_dirty),
        .wr_tag   (req_tag),
        .wr_data  (wr_data),
        .rd_valid (rd_valid[1]),
        .rd_dirty (rd_dirty[1]),
        .rd_tag   (rd_tag[1]),
        .rd_data  (rd_data[1])
    );

    a_one_way_hit: assert property (@(posedge g) disable iff (!rst_n)
        state == cache_op_pkg::ST_LOOKUP |-> !(&hit));
    a_mem_req_held: assert property (@(posedge g) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req);
    a_rsp_pulse: assert property (@(posedge g) disable iff (!rst_n)
        rsp |=> !rsp);

endmodule

// ==== verilog/dcache_sys.sv ====
`timescale 1ns/10ps

module dcache_sys (
    input  logic                                 g,
    input  logic                                 rst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [cache_geom_pkg::addr_w-1:0]    paddr,
    input  logic [cache_geom_pkg::word_w-1:0]    pwdata,
    output logic [cache_geom_pkg::word_w-1:0]    prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    logic req;
    cache_op_pkg::op_e req_op;
    logic [cache_geom_pkg::index_w-1:0] req_index;
    logic [cache_geom_pkg::tag_w-1:0] req_tag;
    logic [cache_geom_pkg::word_w-1:0] req_wdata;
    logic rsp;
    logic [cache_geom_pkg::word_w-1:0] rsp_rdata;
    logic mem_req;
    logic mem_we;
    logic [cache_geom_pkg::mem_words_log2-1:0] mem_addr;
    logic [cache_geom_pkg::word_w-1:0] mem_wdata;
    logic mem_ack;
    logic [cache_geom_pkg::word_w-1:0] mem_rdata;

    apb_front u_apb_front (
        .g         (g),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req       (req),
        .req_op    (req_op),
        .req_index (req_index),
        .req_tag   (req_tag),
        .req_wdata (req_wdata),
        .rsp       (rsp),
        .rsp_rdata (rsp_rdata)
    );

    dcache u_dcache (
        .g         (g),
        .rst_n     (rst_n),
        .req       (req),
        .req_op    (req_op),
        .req_index (req_index),
        .req_tag   (req_tag),
        .req_wdata (req_wdata),
        .rsp       (rsp),
        .rsp_rdata (rsp_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    backing_mem u_backing_mem (
        .g         (g),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== verilog/way_ram.sv ====
`timescale 1ns/10ps

module way_ram (
    input  logic                                 g,
    input  logic                                 rst_n,
    input  logic [cache_geom_pkg::index_w-1:0]   rd_index,
    input  logic                                 wr_en,
    input  logic [cache_geom_pkg::index_w-1:0]   wr_index,
    input  logic                                 wr_valid,
    input  logic                                 wr_dirty,
    input  logic [cache_geom_pkg::tag_w-1:0]     wr_tag,
    input  logic [cache_geom_pkg::word_w-1:0]    wr_data,
    output logic                                 rd_valid,
    output logic                                 rd_dirty,
    output logic [cache_geom_pkg::tag_w-1:0]     rd_tag,
    output logic [cache_geom_pkg::word_w-1:0]    rd_data
);

    logic [cache_geom_pkg::num_sets-1:0] valid_q;
    logic                                dirty_mem [cache_geom_pkg::num_sets];
    logic [cache_geom_pkg::tag_w-1:0]    tag_mem [cache_geom_pkg::num_sets];
    logic [cache_geom_pkg::word_w-1:0]   data_mem [cache_geom_pkg::num_sets];

    // Valid bits live in flops so that reset empties the whole way at once.
    always_ff @(posedge g or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= wr_valid;
            end
            rd_valid <= valid_q[rd_index];
        end
    end

    always_ff @(posedge g) begin
        if (wr_en) begin
            dirty_mem[wr_index] <= wr_dirty;
            tag_mem[wr_index] <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
        rd_dirty <= dirty_mem[rd_index];       // Old contents on a same-set write.
        rd_tag <= tag_mem[rd_index];
        rd_data <= data_mem[rd_index];
    end

endmodule
